/* logic/rmii_rx_config.svh */
`ifndef RMII_RX_CONFIG_SVH
`define RMII_RX_CONFIG_SVH

// rmii receive bus, one dibit per refclk
`define RMII_DATA_WIDTH 2

// packed payload word toward the host side
`define RMII_WORD_WIDTH 32

// good-frame counter width
`define RMII_COUNT_WIDTH 14

// default station address, first octet in the top byte
`define RMII_STATION_MAC 48'h37_38_38_38_38_38

// broadcast destination
`define RMII_BROADCAST_MAC 48'hFFFF_FFFF_FFFF

// crc-32 remainder over frame plus fcs, normal bit order
`define RMII_CRC_RESIDUE 32'hC704DD7B

`endif

/* logic/rmii_rx_pkg.sv */
`include "rmii_rx_config.svh"

package rmii_rx_pkg;

  // one rmii symbol
  typedef logic [`RMII_DATA_WIDTH-1:0] dibit_t;

  // dibit stream between stages
  // data only meaningful while valid is high
  // frame ends on the first cycle with valid low
  typedef struct packed {
    logic   valid;
    dibit_t data;
  } dibit_stream_t;

  // packed output word, valid pulses once per word
  // first payload byte sits in the top bits
  typedef struct packed {
    logic                        valid;
    logic [`RMII_WORD_WIDTH-1:0] data;
  } word_stream_t;

  // end-of-frame report from the crc checker
  // kill only meaningful while done is high
  typedef struct packed {
    logic done;
    logic kill;
  } frame_status_t;

endpackage

/* logic/preamble_strip.sv */
`timescale 1ns/10ps

module preamble_strip (
  input  logic                       eth_refclk,
  input  logic                       arst_n,
  input  rmii_rx_pkg::dibit_t        rxd,
  input  logic                       crs_dv,
  output rmii_rx_pkg::dibit_stream_t strip_s
);
  import rmii_rx_pkg::*;

  // preamble octet 0x55 shows up as 01 on the wire
  localparam dibit_t pre_dibit = 2'b01;
  // last dibit of the 0xD5 delimiter
  localparam dibit_t sfd_dibit = 2'b11;

  typedef enum logic [1:0] {
    st_idle,
    st_preamble,
    st_data
  } state_t;

  state_t state_q;
  state_t state_d;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        // carrier may rise on 00 symbols, wait for real preamble
        if (crs_dv && rxd == pre_dibit) begin
          state_d = st_preamble;
        end
      end
      st_preamble: begin
        // carrier lost before delimiter, nothing emitted
        if (!crs_dv) begin
          state_d = st_idle;
        end else if (rxd == sfd_dibit) begin
          state_d = st_data;
        end
      end
      st_data: begin
        if (!crs_dv) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  // state and registered frame output
  always_ff @(posedge eth_refclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      strip_s <= '0;
    end else begin
      state_q <= state_d;
      // one cycle behind rxd, drops one cycle after crs_dv
      strip_s.valid <= (state_q == st_data) && crs_dv;
      strip_s.data  <= rxd;
    end
  end

endmodule

/* logic/bit_reorder.sv */
`timescale 1ns/10ps

module bit_reorder (
  input  logic                       eth_refclk,
  input  logic                       arst_n,
  input  rmii_rx_pkg::dibit_stream_t in_s,
  output rmii_rx_pkg::dibit_stream_t out_s
);
  import rmii_rx_pkg::*;

  // two byte buffers, lower three dibits only
  // top dibit goes out straight from the input
  dibit_t     byte_buf [2][3];
  logic       wr_sel;
  logic       rd_sel;
  logic [1:0] wr_cnt;
  logic [1:0] rd_cnt;
  // buffer holds a complete byte still being replayed
  logic [1:0] full;
  logic       byte_end;

  // fourth dibit of a byte on the input
  assign byte_end = in_s.valid && (wr_cnt == 2'd3);

  always_ff @(posedge eth_refclk) begin
    if (in_s.valid && !byte_end) begin
      byte_buf[wr_sel][wr_cnt] <= in_s.data;
    end
  end

  always_ff @(posedge eth_refclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_sel <= 1'b0;
      rd_sel <= 1'b0;
      wr_cnt <= 2'd0;
      rd_cnt <= 2'd0;
      full   <= 2'b00;
      out_s  <= '0;
    end else begin
      out_s.valid <= 1'b0;
      // partial byte at frame end is dropped
      wr_cnt <= in_s.valid ? wr_cnt + 2'd1 : 2'd0;
      if (byte_end) begin
        // msb dibit leaves now, switch write side to other buffer
        wr_sel       <= ~wr_sel;
        rd_sel       <= wr_sel;
        rd_cnt       <= 2'd2;
        full[wr_sel] <= 1'b1;
        out_s.valid  <= 1'b1;
        out_s.data   <= in_s.data;
      end else if (full[rd_sel]) begin
        // replay remaining dibits from the top down
        out_s.valid <= 1'b1;
        out_s.data  <= byte_buf[rd_sel][rd_cnt];
        rd_cnt      <= rd_cnt - 2'd1;
        if (rd_cnt == 2'd0) begin
          full[rd_sel] <= 1'b0;
        end
      end
    end
  end

endmodule

/* logic/mac_filter.sv */
`timescale 1ns/10ps
`include "rmii_rx_config.svh"

module mac_filter #(
  parameter logic [47:0] station_mac = `RMII_STATION_MAC
) (
  input  logic                       eth_refclk,
  input  logic                       arst_n,
  input  rmii_rx_pkg::dibit_stream_t in_s,
  output rmii_rx_pkg::dibit_stream_t out_s,
  output logic                       accept
);
  import rmii_rx_pkg::*;

  // destination address length, then both addresses
  localparam int dst_dibits = 24;
  localparam int hdr_dibits = 48;

  // addresses as dibit vectors, index 23 is the first on the wire
  localparam dibit_t [23:0] station_dibits = station_mac;
  localparam dibit_t [23:0] bcast_dibits   = `RMII_BROADCAST_MAC;

  // saturates at hdr_dibits for the payload
  logic   [5:0]  dib_cnt;
  logic   [4:0]  ref_idx;
  logic          st_run;
  logic          bc_run;
  logic          st_hit;
  logic          bc_hit;

  // reference dibit for the current position
  assign ref_idx = (dib_cnt < 6'(dst_dibits)) ? 5'(dst_dibits - 1 - int'(dib_cnt)) : 5'd0;

  // running match, restarted on the first dibit
  assign st_hit = (in_s.data == station_dibits[ref_idx]) && (dib_cnt == 6'd0 || st_run);
  assign bc_hit = (in_s.data == bcast_dibits[ref_idx]) && (dib_cnt == 6'd0 || bc_run);

  always_ff @(posedge eth_refclk or negedge arst_n) begin
    if (!arst_n) begin
      dib_cnt <= 6'd0;
      st_run  <= 1'b0;
      bc_run  <= 1'b0;
      accept  <= 1'b0;
      out_s   <= '0;
    end else begin
      // addresses never leave, payload only for a matching frame
      out_s.valid <= in_s.valid && (dib_cnt == 6'(hdr_dibits)) && accept;
      out_s.data  <= in_s.data;
      if (!in_s.valid) begin
        dib_cnt <= 6'd0;
      end else begin
        if (dib_cnt != 6'(hdr_dibits)) begin
          dib_cnt <= dib_cnt + 6'd1;
        end
        if (dib_cnt < 6'(dst_dibits)) begin
          st_run <= st_hit;
          bc_run <= bc_hit;
        end
        // decision on the last destination dibit, held to next frame
        if (dib_cnt == 6'(dst_dibits - 1)) begin
          accept <= st_hit || bc_hit;
        end
      end
    end
  end

endmodule

/* logic/word_pack.sv */
`timescale 1ns/10ps
`include "rmii_rx_config.svh"

module word_pack (
  input  logic                       eth_refclk,
  input  logic                       arst_n,
  input  rmii_rx_pkg::dibit_stream_t in_s,
  output rmii_rx_pkg::word_stream_t  word_out
);

  // msb-first dibits shift in from the bottom
  logic [`RMII_WORD_WIDTH-1:0] shreg;
  // dibit position inside the current word
  logic [3:0]                  pos_cnt;
  logic                        word_vld;

  // shreg holds the full word in the pulse cycle
  assign word_out = '{valid: word_vld, data: shreg};

  always_ff @(posedge eth_refclk) begin
    if (in_s.valid) begin
      shreg <= {shreg[`RMII_WORD_WIDTH-`RMII_DATA_WIDTH-1:0], in_s.data};
    end
  end

  always_ff @(posedge eth_refclk or negedge arst_n) begin
    if (!arst_n) begin
      pos_cnt  <= 4'd0;
      word_vld <= 1'b0;
    end else begin
      // sixteenth dibit completes the word
      word_vld <= in_s.valid && (pos_cnt == 4'hf);
      // leftover dibits dropped at frame end
      if (in_s.valid) begin
        pos_cnt <= pos_cnt + 4'd1;
      end else begin
        pos_cnt <= 4'd0;
      end
    end
  end

endmodule

/* logic/frame_check.sv */
`timescale 1ns/10ps
`include "rmii_rx_config.svh"

module frame_check (
  input  logic                                eth_refclk,
  input  logic                                arst_n,
  input  rmii_rx_pkg::dibit_stream_t          in_s,
  input  logic                                accept,
  output rmii_rx_pkg::frame_status_t          status,
  output logic [`RMII_COUNT_WIDTH-1:0]        good_count
);
  import rmii_rx_pkg::*;

  // 04C11DB7 bit-reversed, for the lsb-first register
  localparam logic [31:0] crc_poly_rev = 32'hEDB88320;
  localparam logic [31:0] crc_preset   = 32'hFFFF_FFFF;

  // one refclk worth of crc, bit 0 is first on the wire
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input dibit_t d);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < `RMII_DATA_WIDTH; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ crc_poly_rev;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  logic [31:0] crc_q;
  // register in normal bit order for the residue compare
  logic [31:0] crc_norm;
  logic        in_vld_q;
  logic        frame_end;
  logic        crc_bad;

  // first idle cycle after a frame
  assign frame_end = in_vld_q && !in_s.valid;
  assign crc_norm  = {<<{crc_q}};
  // fcs included, so a good frame leaves the fixed residue
  assign crc_bad   = (crc_norm != `RMII_CRC_RESIDUE);

  always_ff @(posedge eth_refclk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q      <= crc_preset;
      in_vld_q   <= 1'b0;
      status     <= '0;
      good_count <= '0;
    end else begin
      in_vld_q    <= in_s.valid;
      status.done <= frame_end;
      // preset again between frames
      if (in_s.valid) begin
        crc_q <= crc_step(crc_q, in_s.data);
      end else begin
        crc_q <= crc_preset;
      end
      if (frame_end) begin
        // kill holds until the next frame ends
        status.kill <= crc_bad;
        // accept was settled early in the address field
        if (accept && !crc_bad) begin
          good_count <= good_count + (`RMII_COUNT_WIDTH)'(1);
        end
      end
    end
  end

endmodule

/* logic/rmii_rx_top.sv */
`timescale 1ns/10ps
`include "rmii_rx_config.svh"

module rmii_rx_top (
  input  logic                               eth_refclk,
  input  logic                               arst_n,
  input  rmii_rx_pkg::dibit_t                rxd,
  input  logic                               crs_dv,
  output rmii_rx_pkg::word_stream_t          word_out,
  output rmii_rx_pkg::frame_status_t         status,
  output logic [`RMII_COUNT_WIDTH-1:0]       good_count
);
  import rmii_rx_pkg::*;

  // raw frame dibits, lsb-first, preamble gone
  dibit_stream_t strip_s;
  // msb-first dibits, four cycles later
  dibit_stream_t order_s;
  // payload of frames for this station only
  dibit_stream_t filt_s;
  // destination match for the current frame
  logic          accept;

  preamble_strip preamble_strip_i (
    .eth_refclk (eth_refclk),
    .arst_n     (arst_n),
    .rxd        (rxd),
    .crs_dv     (crs_dv),
    .strip_s    (strip_s)
  );

  bit_reorder bit_reorder_i (
    .eth_refclk (eth_refclk),
    .arst_n     (arst_n),
    .in_s       (strip_s),
    .out_s      (order_s)
  );

  mac_filter mac_filter_i (
    .eth_refclk (eth_refclk),
    .arst_n     (arst_n),
    .in_s       (order_s),
    .out_s      (filt_s),
    .accept     (accept)
  );

  word_pack word_pack_i (
    .eth_refclk (eth_refclk),
    .arst_n     (arst_n),
    .in_s       (filt_s),
    .word_out   (word_out)
  );

  // crc runs on the wire order, tapped before the reorder
  frame_check frame_check_i (
    .eth_refclk (eth_refclk),
    .arst_n     (arst_n),
    .in_s       (strip_s),
    .accept     (accept),
    .status     (status),
    .good_count (good_count)
  );

endmodule

/* testbench/rmii_rx_tb.sv */
`timescale 1ns/10ps
`include "rmii_rx_config.svh"

module rmii_rx_tb;
  import rmii_rx_pkg::*;

  logic                         eth_refclk;
  logic                         arst_n;
  dibit_t                       rxd;
  logic                         crs_dv;
  word_stream_t                 word_out;
  frame_status_t                status;
  logic [`RMII_COUNT_WIDTH-1:0] good_count;

  // pattern memory, one value per entry
  logic [31:0] pat [0:511];
  logic [31:0] exp_words [$];
  logic [31:0] got_words [$];
  logic        exp_kill [$];
  int          exp_count [$];
  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;
  int          good_expected;
  logic [31:0] rng;

  rmii_rx_top dut_i (
    .eth_refclk (eth_refclk),
    .arst_n     (arst_n),
    .rxd        (rxd),
    .crs_dv     (crs_dv),
    .word_out   (word_out),
    .status     (status),
    .good_count (good_count)
  );

  initial begin
    eth_refclk = 1'b0;
    forever #20 eth_refclk = ~eth_refclk;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reflected crc-32 over whole bytes, lsb first
  function automatic logic [31:0] fcs_of(input logic [7:0] b [$]);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    foreach (b[i]) begin
      c = c ^ {24'd0, b[i]};
      for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic drive_dibit(input dibit_t d, input logic dv);
    @(posedge eth_refclk);
    #2;
    rxd    = d;
    crs_dv = dv;
  endtask

  task automatic idle_gap();
    int n;
    rng = xorshift(rng);
    n   = 12 + int'(rng % 32'd16);
    for (int i = 0; i < n; i++) begin
      drive_dibit(2'b00, 1'b0);
    end
  endtask

  task automatic send_frame(input logic [7:0] b [$]);
    for (int i = 0; i < 28; i++) begin
      drive_dibit(2'b01, 1'b1);
    end
    drive_dibit(2'b11, 1'b1);
    // least significant dibit first on the wire
    foreach (b[i]) begin
      for (int k = 0; k < 4; k++) begin
        drive_dibit(dibit_t'(b[i] >> (2 * k)), 1'b1);
      end
    end
    idle_gap();
  endtask

  // carrier lost partway into the preamble
  task automatic send_abort();
    for (int i = 0; i < 10; i++) begin
      drive_dibit(2'b01, 1'b1);
    end
    idle_gap();
  endtask

  // words and status sampled away from the driving edge
  always @(negedge eth_refclk) begin
    if (arst_n) begin
      if (word_out.valid) begin
        got_words.push_back(word_out.data);
      end
      if (status.done) begin
        if (exp_kill.size() == 0) begin
          errors++;
          $display("done pulse at %0t with no frame expected", $time);
        end else begin
          check_value("status.kill", {31'd0, exp_kill.pop_front()}, {31'd0, status.kill});
          check_value("good_count", exp_count.pop_front(), {18'd0, good_count});
        end
      end
    end
  end

  always @(posedge eth_refclk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, run did not complete", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    logic [7:0] fb [$];
    int ptr;
    int nframes;
    int nbytes;
    int nw;
    int words_total;
    logic acc;
    logic ok;
    logic [31:0] fcs;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    good_expected = 0;
    words_total   = 0;
    rng           = 32'h1374c099;
    rxd           = 2'b00;
    crs_dv        = 1'b0;
    arst_n        = 1'b0;
    $readmemh("testbench/rmii_rx_patterns.txt", pat);
    nframes = int'(pat[0]);
    // dibits per frame plus the widest gap, then drain margin
    cycle_limit = 200;
    ptr = 1;
    for (int f = 0; f < nframes; f++) begin
      nbytes = int'(pat[ptr]);
      cycle_limit += 28 + ((nbytes == 0) ? 10 : 29 + 4 * (nbytes + 4));
      ptr += 4 + nbytes;
    end
    repeat (16) @(posedge eth_refclk);
    #2;
    arst_n = 1'b1;
    ptr = 1;
    for (int f = 0; f < nframes; f++) begin
      nbytes = int'(pat[ptr]);
      acc    = pat[ptr + 1][0];
      ok     = pat[ptr + 2][0];
      nw     = int'(pat[ptr + 3]);
      ptr += 4;
      fb.delete();
      for (int i = 0; i < nbytes; i++) begin
        fb.push_back(pat[ptr + i][7:0]);
      end
      ptr += nbytes;
      // earlier frames have left the pipeline by the end of their gap
      check_value("word_count", words_total, got_words.size());
      words_total += nw;
      if (nbytes == 0) begin
        send_abort();
      end else begin
        fcs = fcs_of(fb);
        for (int k = 0; k < 4; k++) begin
          fb.push_back(fcs[8*k +: 8]);
        end
        if (!ok) begin
          fb[nbytes] = fb[nbytes] ^ 8'h01;
        end
        // payload after both addresses, first byte on top
        if (acc) begin
          for (int i = 12; i + 3 < fb.size(); i += 4) begin
            exp_words.push_back({fb[i], fb[i + 1], fb[i + 2], fb[i + 3]});
          end
        end
        if (acc && ok) begin
          good_expected++;
        end
        exp_kill.push_back(!ok);
        exp_count.push_back(good_expected);
        send_frame(fb);
      end
    end
    repeat (20) @(posedge eth_refclk);
    while (exp_words.size() > 0 && got_words.size() > 0) begin
      check_value("word_out.data", exp_words.pop_front(), got_words.pop_front());
    end
    if (exp_words.size() > 0) begin
      errors++;
      $display("%0d expected words never appeared on word_out", exp_words.size());
    end
    if (got_words.size() > 0) begin
      errors++;
      $display("%0d extra words appeared on word_out", got_words.size());
    end
    if (exp_kill.size() > 0) begin
      errors++;
      $display("%0d frames ended without a done pulse", exp_kill.size());
    end
    check_value("good_count", good_expected, {18'd0, good_count});
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* rmii_rx.f */
+incdir+logic
logic/rmii_rx_pkg.sv
logic/preamble_strip.sv
logic/bit_reorder.sv
logic/mac_filter.sv
logic/word_pack.sv
logic/frame_check.sv
logic/rmii_rx_top.sv
testbench/rmii_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rmii receive testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f rmii_rx.f \
  --top-module rmii_rx_tb \
  -o rmii_rx_sim

sim_out=$(./obj_dir/rmii_rx_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TB PASSED$"; then
  exit 0
else
  exit 1
fi

/* testbench/rmii_rx_patterns.txt */
// first entry: frame count
// per frame: byte count, accept, crc_ok, word count, then frame bytes without fcs
// fcs appended by the testbench, crc_ok 0 means first fcs byte corrupted
// byte count 0 is a carrier that drops inside the preamble
6
// station address, good fcs
16 1 1 3
37 38 38 38 38 38 02 00 00 00 00 01
10 11 12 13 14 15 16 17 18 19
// broadcast, good fcs
14 1 1 3
ff ff ff ff ff ff 02 00 00 00 00 01
20 21 22 23 24 25 26 27
// other station, dropped
12 0 1 0
37 38 38 38 38 39 02 00 00 00 00 01
30 31 32 33 34 35
// aborted preamble
0 0 0 0
// station address, bad fcs
15 1 0 3
37 38 38 38 38 38 02 00 00 00 00 01
40 41 42 43 44 45 46 47 48
// station address, longer payload
1c 1 1 5
37 38 38 38 38 38 02 00 00 00 00 01
50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
